// ==== dcache_macros.svh ====
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// idle cycles between an accepted address and the first read beat
// or the write response
`define MEM_LATENCY 4

// memory depth in 64-bit words, 8 KiB in all
// only address bits 12:3 select a word, higher bits alias
`define MEM_WORDS 1024

`endif

// ==== cache_pkg.sv ====
package cache_pkg;

	// byte address from the core
	typedef logic [31:0] addr_t;
	// one data word
	typedef logic [63:0] word_t;
	// byte enables, one bit per byte of word_t
	typedef logic [7:0] mask_t;
	// address fields: tag 31:10, index 9:6, word 5:3
	typedef logic [21:0] tag_t;
	typedef logic [3:0] index_t;
	typedef logic [2:0] word_sel_t;
	// one-hot way select over the four ways
	typedef logic [3:0] way_t;
	// statistics counters wrap at 32 bits
	typedef logic [31:0] count_t;

	typedef enum logic [2:0] {
		s_idle,
		// answer cycle, ready is high here
		s_lookup,
		s_fill,
		s_write,
		s_wresp,
		s_single
	} cache_state_t;

endpackage

// ==== mem_pkg.sv ====
package mem_pkg;

	// beat number inside a burst, ar_len uses it as beats minus one
	typedef logic [2:0] beat_cnt_t;
	// write response code
	typedef logic [1:0] resp_t;
	// configuration register select
	typedef logic [1:0] cfg_addr_t;

	// full line burst is eight beats
	localparam beat_cnt_t BURST_LAST = 3'd7;
	localparam resp_t RESP_OKAY = 2'b00;

	// register map of the configuration block
	localparam cfg_addr_t CFG_CTRL = 2'd0;
	localparam cfg_addr_t CFG_BOUND = 2'd1;
	localparam cfg_addr_t CFG_HITS = 2'd2;
	localparam cfg_addr_t CFG_MISSES = 2'd3;

endpackage

// ==== dcache_cfg_regs.sv ====
`timescale 1ns/100ps

module dcache_cfg_regs (
	input  logic                clk,
	input  logic                rst,
	input  logic                cfg_we,
	input  mem_pkg::cfg_addr_t  cfg_addr,
	input  cache_pkg::addr_t    cfg_wdata,
	input  logic                hit_evt,
	input  logic                miss_evt,
	output cache_pkg::count_t   cfg_rdata,
	output logic                enable,
	output cache_pkg::addr_t    bound,
	output logic                inval
);
	cache_pkg::count_t hit_cnt;
	cache_pkg::count_t miss_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			enable <= 1'b1;
			// bound at top of memory, everything cacheable
			bound <= 32'h0000_2000;
			inval <= 1'b0;
			hit_cnt <= '0;
			miss_cnt <= '0;
		end else begin
			// invalidate is a self-clearing command bit
			inval <= cfg_we && (cfg_addr == mem_pkg::CFG_CTRL) && cfg_wdata[1];
			if (cfg_we && (cfg_addr == mem_pkg::CFG_CTRL)) begin
				enable <= cfg_wdata[0];
			end
			if (cfg_we && (cfg_addr == mem_pkg::CFG_BOUND)) begin
				bound <= cfg_wdata;
			end
			// any write to a counter clears it, clear beats a same-cycle event
			if (cfg_we && (cfg_addr == mem_pkg::CFG_HITS)) begin
				hit_cnt <= '0;
			end else if (hit_evt) begin
				hit_cnt <= hit_cnt + 32'd1;
			end
			if (cfg_we && (cfg_addr == mem_pkg::CFG_MISSES)) begin
				miss_cnt <= '0;
			end else if (miss_evt) begin
				miss_cnt <= miss_cnt + 32'd1;
			end
		end
	end

	// readback straight from cfg_addr
	always_comb begin
		case (cfg_addr)
			mem_pkg::CFG_CTRL: cfg_rdata = {31'b0, enable};
			mem_pkg::CFG_BOUND: cfg_rdata = bound;
			mem_pkg::CFG_HITS: cfg_rdata = hit_cnt;
			default: cfg_rdata = miss_cnt;
		endcase
	end

endmodule

// ==== dcache_tag_array.sv ====
`timescale 1ns/100ps

module dcache_tag_array (
	input  logic              clk,
	input  logic              rst,
	input  logic              inval,
	input  cache_pkg::addr_t  lookup_addr,
	input  logic              fill_en,
	output cache_pkg::way_t   hit_way,
	output cache_pkg::way_t   victim_way
);
	cache_pkg::tag_t tags [4][16];
	logic [15:0] valid_bits [4];
	// round-robin fill pointer, one per set
	logic [1:0] fill_ptr [16];
	cache_pkg::tag_t lk_tag;
	cache_pkg::index_t lk_index;

	assign lk_tag = lookup_addr[31:10];
	assign lk_index = lookup_addr[9:6];

	// compare all four ways of the set at once
	always_comb begin
		for (int w = 0; w < 4; w++) begin
			hit_way[w] = valid_bits[w][lk_index] && (tags[w][lk_index] == lk_tag);
		end
	end

	// pointer as one-hot, steady until the fill completes
	assign victim_way = cache_pkg::way_t'(4'b0001 << fill_ptr[lk_index]);

	always_ff @(posedge clk) begin
		for (int w = 0; w < 4; w++) begin
			if (fill_en && victim_way[w]) begin
				tags[w][lk_index] <= lk_tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < 4; w++) begin
				valid_bits[w] <= '0;
			end
			for (int s = 0; s < 16; s++) begin
				fill_ptr[s] <= 2'd0;
			end
		end else begin
			// invalidate all wins over a fill on the same edge
			for (int w = 0; w < 4; w++) begin
				if (inval) begin
					valid_bits[w] <= '0;
				end else if (fill_en && victim_way[w]) begin
					valid_bits[w][lk_index] <= 1'b1;
				end
			end
			if (fill_en) begin
				fill_ptr[lk_index] <= fill_ptr[lk_index] + 2'd1;
			end
		end
	end

	// a tag is filled only into a way that missed, so two ways never match
	a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_way));

endmodule

// ==== dcache_data_array.sv ====
`timescale 1ns/100ps

module dcache_data_array (
	input  logic                  clk,
	input  cache_pkg::way_t       we_way,
	input  cache_pkg::way_t       rd_way,
	input  cache_pkg::index_t     index,
	input  cache_pkg::word_sel_t  word_sel,
	input  cache_pkg::word_t      wdata,
	input  cache_pkg::mask_t      wmask,
	output cache_pkg::word_t      rdata
);
	// per way 16 lines of 8 words, {index, word_sel} picks one word
	cache_pkg::word_t mem [4][128];
	logic [6:0] word_addr;
	cache_pkg::word_t rd_mux;

	assign word_addr = {index, word_sel};

	// byte-masked write into the selected way
	always_ff @(posedge clk) begin
		for (int w = 0; w < 4; w++) begin
			if (we_way[w]) begin
				for (int b = 0; b < 8; b++) begin
					if (wmask[b]) begin
						mem[w][word_addr][8*b +: 8] <= wdata[8*b +: 8];
					end
				end
			end
		end
	end

	// no way selected reads as zero
	always_comb begin
		rd_mux = '0;
		for (int w = 0; w < 4; w++) begin
			if (rd_way[w]) begin
				rd_mux = rd_mux | mem[w][word_addr];
			end
		end
	end

	// word shows up the cycle after the lookup
	always_ff @(posedge clk) begin
		rdata <= rd_mux;
	end

	// hit write and fill both target a single way
	a_we_onehot: assert property (@(posedge clk) $onehot0(we_way));

endmodule

// ==== dcache_ctrl.sv ====
`timescale 1ns/100ps

module dcache_ctrl (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  valid,
	input  logic                  wren,
	input  cache_pkg::addr_t      addr,
	input  cache_pkg::word_t      din,
	input  cache_pkg::mask_t      mask,
	output logic                  ready,
	output cache_pkg::word_t      dout,
	input  logic                  enable,
	input  cache_pkg::addr_t      bound,
	output logic                  hit_evt,
	output logic                  miss_evt,
	input  cache_pkg::way_t       hit_way,
	input  cache_pkg::way_t       victim_way,
	output logic                  fill_en,
	output cache_pkg::way_t       we_way,
	output cache_pkg::way_t       rd_way,
	output cache_pkg::word_sel_t  word_sel,
	output cache_pkg::word_t      wdata_arr,
	output cache_pkg::mask_t      wmask_arr,
	input  cache_pkg::word_t      rdata_arr,
	output logic                  ar_valid,
	output cache_pkg::addr_t      ar_addr,
	output mem_pkg::beat_cnt_t    ar_len,
	input  logic                  ar_ready,
	input  logic                  r_valid,
	input  cache_pkg::word_t      r_data,
	input  logic                  r_last,
	output logic                  aw_valid,
	output cache_pkg::addr_t      aw_addr,
	output cache_pkg::word_t      w_data,
	output cache_pkg::mask_t      w_strb,
	input  logic                  aw_ready,
	input  logic                  b_valid,
	input  mem_pkg::resp_t        b_resp
);
	cache_pkg::cache_state_t state;
	mem_pkg::beat_cnt_t beat_cnt;
	cache_pkg::word_t resp_q;
	cache_pkg::word_sel_t req_word;
	logic from_arr;
	logic cached;
	logic hit;
	logic in_idle;
	logic in_fill;

	assign req_word = addr[5:3];
	// cacheable only when enabled and below the bound
	// everything else is a single beat to memory
	assign cached = enable && (addr < bound);
	assign hit = |hit_way;
	assign in_idle = (state == cache_pkg::s_idle);
	assign in_fill = (state == cache_pkg::s_fill);

	// each request is sampled once in idle so a cached read gives one event
	assign hit_evt = in_idle && valid && !wren && cached && hit;
	assign miss_evt = in_idle && valid && !wren && cached && !hit;
	// tag written with the last beat
	assign fill_en = in_fill && r_valid && r_last;

	// fill beats go to the victim way
	// a write-through updates the word only if it is resident
	always_comb begin
		we_way = '0;
		if (in_fill && r_valid) begin
			we_way = victim_way;
		end else if (in_idle && valid && wren && cached) begin
			we_way = hit_way;
		end
	end
	assign rd_way = hit_way;
	assign word_sel = in_fill ? beat_cnt : req_word;
	assign wdata_arr = in_fill ? r_data : din;
	assign wmask_arr = in_fill ? 8'hff : mask;

	// a hit answers from the array and every other path from resp_q
	assign dout = from_arr ? rdata_arr : resp_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= cache_pkg::s_idle;
			ready <= 1'b0;
			ar_valid <= 1'b0;
			aw_valid <= 1'b0;
			from_arr <= 1'b0;
			beat_cnt <= '0;
		end else begin
			ready <= 1'b0;
			case (state)
				cache_pkg::s_idle: begin
					from_arr <= 1'b0;
					beat_cnt <= '0;
					if (valid) begin
						if (wren) begin
							aw_valid <= 1'b1;
							state <= cache_pkg::s_write;
						end else if (!cached) begin
							ar_valid <= 1'b1;
							state <= cache_pkg::s_single;
						end else if (hit) begin
							ready <= 1'b1;
							from_arr <= 1'b1;
							state <= cache_pkg::s_lookup;
						end else begin
							ar_valid <= 1'b1;
							state <= cache_pkg::s_fill;
						end
					end
				end
				// ready is up here and valid drops or changes after it
				cache_pkg::s_lookup: state <= cache_pkg::s_idle;
				cache_pkg::s_fill, cache_pkg::s_single: begin
					if (ar_ready) begin
						ar_valid <= 1'b0;
					end
					if (r_valid) begin
						beat_cnt <= beat_cnt + 3'd1;
					end
					if (r_valid && r_last) begin
						ready <= 1'b1;
						state <= cache_pkg::s_lookup;
					end
				end
				cache_pkg::s_write: begin
					if (aw_ready) begin
						aw_valid <= 1'b0;
						state <= cache_pkg::s_wresp;
					end
				end
				cache_pkg::s_wresp: begin
					if (b_valid) begin
						ready <= 1'b1;
						state <= cache_pkg::s_lookup;
					end
				end
				default: state <= cache_pkg::s_idle;
			endcase
		end
	end

	// channel payload loaded with the request
	always_ff @(posedge clk) begin
		if (in_idle && valid) begin
			// line-aligned burst for a fill and a single word otherwise
			ar_addr <= cached ? {addr[31:6], 6'b0} : {addr[31:3], 3'b0};
			ar_len <= cached ? mem_pkg::BURST_LAST : 3'd0;
			aw_addr <= addr;
			w_data <= din;
			w_strb <= mask;
		end
		// pick the requested word as the burst streams past
		if (r_valid && ((state == cache_pkg::s_single) || (beat_cnt == req_word))) begin
			resp_q <= r_data;
		end
	end

	a_ready_valid: assert property (@(posedge clk) disable iff (rst) ready |-> valid);
	a_one_channel: assert property (@(posedge clk) disable iff (rst) !(ar_valid && aw_valid));

endmodule

// ==== burst_mem.sv ====
`timescale 1ns/100ps
`include "dcache_macros.svh"

module burst_mem (
	input  logic                clk,
	input  logic                rst,
	input  logic                ar_valid,
	input  cache_pkg::addr_t    ar_addr,
	input  mem_pkg::beat_cnt_t  ar_len,
	output logic                ar_ready,
	output logic                r_valid,
	output cache_pkg::word_t    r_data,
	output logic                r_last,
	input  logic                aw_valid,
	input  cache_pkg::addr_t    aw_addr,
	input  cache_pkg::word_t    w_data,
	input  cache_pkg::mask_t    w_strb,
	output logic                aw_ready,
	output logic                b_valid,
	output mem_pkg::resp_t      b_resp
);
	localparam int WORD_BITS = $clog2(`MEM_WORDS);

	cache_pkg::word_t mem [`MEM_WORDS];
	logic busy;
	logic is_wr;
	logic [7:0] lat_cnt;
	logic [WORD_BITS-1:0] rd_ptr;
	mem_pkg::beat_cnt_t beat;
	mem_pkg::beat_cnt_t last_beat;
	logic rd_fire;
	logic wr_fire;
	logic done_wait;

	initial begin
		for (int i = 0; i < `MEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	// one transaction at a time, reads win a tie
	assign ar_ready = !busy;
	assign aw_ready = !busy && !ar_valid;
	assign rd_fire = ar_valid && ar_ready;
	assign wr_fire = aw_valid && aw_ready;

	// latency spent, answer phase
	assign done_wait = busy && (lat_cnt == 8'd0);
	assign r_valid = done_wait && !is_wr;
	assign r_data = mem[rd_ptr];
	assign r_last = r_valid && (beat == last_beat);
	assign b_valid = done_wait && is_wr;
	assign b_resp = mem_pkg::RESP_OKAY;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			is_wr <= 1'b0;
			lat_cnt <= 8'd0;
			beat <= '0;
		end else if (!busy) begin
			if (rd_fire || wr_fire) begin
				busy <= 1'b1;
				is_wr <= wr_fire;
				lat_cnt <= 8'(`MEM_LATENCY);
				beat <= '0;
			end
		end else if (lat_cnt != 8'd0) begin
			lat_cnt <= lat_cnt - 8'd1;
		end else if (b_valid || r_last) begin
			busy <= 1'b0;
		end else begin
			beat <= beat + 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rd_ptr <= ar_addr[WORD_BITS+2:3];
			last_beat <= ar_len;
		end else if (r_valid) begin
			// wrap inside the 8-word line
			rd_ptr <= {rd_ptr[WORD_BITS-1:3], rd_ptr[2:0] + 3'd1};
		end
		// write lands at accept, response follows after the latency
		if (wr_fire) begin
			for (int b = 0; b < 8; b++) begin
				if (w_strb[b]) begin
					mem[aw_addr[WORD_BITS+2:3]][8*b +: 8] <= w_data[8*b +: 8];
				end
			end
		end
	end

endmodule

// ==== dcache_subsys.sv ====
`timescale 1ns/100ps

module dcache_subsys (
	input  logic                clk,
	input  logic                rst,
	input  logic                valid,
	input  logic                wren,
	input  cache_pkg::addr_t    addr,
	input  cache_pkg::word_t    din,
	input  cache_pkg::mask_t    mask,
	output logic                ready,
	output cache_pkg::word_t    dout,
	input  logic                cfg_we,
	input  mem_pkg::cfg_addr_t  cfg_addr,
	input  cache_pkg::addr_t    cfg_wdata,
	output cache_pkg::count_t   cfg_rdata
);
	// configuration and statistics
	logic enable;
	cache_pkg::addr_t bound;
	logic inval;
	logic hit_evt;
	logic miss_evt;
	// tag and data arrays
	cache_pkg::way_t hit_way;
	cache_pkg::way_t victim_way;
	logic fill_en;
	cache_pkg::way_t we_way;
	cache_pkg::way_t rd_way;
	cache_pkg::word_sel_t word_sel;
	cache_pkg::word_t wdata_arr;
	cache_pkg::mask_t wmask_arr;
	cache_pkg::word_t rdata_arr;
	// memory channels
	logic ar_valid;
	cache_pkg::addr_t ar_addr;
	mem_pkg::beat_cnt_t ar_len;
	logic ar_ready;
	logic r_valid;
	cache_pkg::word_t r_data;
	logic r_last;
	logic aw_valid;
	cache_pkg::addr_t aw_addr;
	cache_pkg::word_t w_data;
	cache_pkg::mask_t w_strb;
	logic aw_ready;
	logic b_valid;
	mem_pkg::resp_t b_resp;

	dcache_cfg_regs cfg_regs_i (
		.clk, .rst, .cfg_we, .cfg_addr, .cfg_wdata, .hit_evt, .miss_evt,
		.cfg_rdata, .enable, .bound, .inval
	);

	// request is held steady, so addr indexes both arrays directly
	dcache_tag_array tag_array_i (
		.clk, .rst, .inval, .lookup_addr(addr), .fill_en, .hit_way, .victim_way
	);

	dcache_data_array data_array_i (
		.clk, .we_way, .rd_way, .index(addr[9:6]), .word_sel,
		.wdata(wdata_arr), .wmask(wmask_arr), .rdata(rdata_arr)
	);

	dcache_ctrl ctrl_i (
		.clk, .rst, .valid, .wren, .addr, .din, .mask, .ready, .dout,
		.enable, .bound, .hit_evt, .miss_evt, .hit_way, .victim_way, .fill_en,
		.we_way, .rd_way, .word_sel, .wdata_arr, .wmask_arr, .rdata_arr,
		.ar_valid, .ar_addr, .ar_len, .ar_ready, .r_valid, .r_data, .r_last,
		.aw_valid, .aw_addr, .w_data, .w_strb, .aw_ready, .b_valid, .b_resp
	);

	burst_mem mem_i (
		.clk, .rst, .ar_valid, .ar_addr, .ar_len, .ar_ready, .r_valid, .r_data,
		.r_last, .aw_valid, .aw_addr, .w_data, .w_strb, .aw_ready, .b_valid, .b_resp
	);

endmodule

// ==== tb_dcache_subsys.sv ====
`timescale 1ns/100ps
`include "dcache_macros.svh"

module tb_dcache_subsys;

	logic clk;
	logic rst;
	// core request port
	logic valid;
	logic wren;
	cache_pkg::addr_t addr;
	cache_pkg::word_t din;
	cache_pkg::mask_t mask;
	logic ready;
	cache_pkg::word_t dout;
	// configuration port
	logic cfg_we;
	mem_pkg::cfg_addr_t cfg_addr;
	cache_pkg::addr_t cfg_wdata;
	cache_pkg::count_t cfg_rdata;

	// vector table, one entry per non-comment line
	logic [7:0] op_q [$];
	cache_pkg::addr_t addr_q [$];
	cache_pkg::word_t data_q [$];
	cache_pkg::mask_t mask_q [$];
	cache_pkg::word_t exp_q [$];
	int vec_count;
	logic loaded;

	dcache_subsys dcache_subsys_i (
		.clk, .rst, .valid, .wren, .addr, .din, .mask, .ready, .dout,
		.cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata
	);

	initial clk = 1'b0;
	// 20 ns period
	always #10 clk = ~clk;

	task automatic check_word(input string name, input cache_pkg::word_t expected,
			input cache_pkg::word_t actual);
		if (actual !== expected) begin
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
			$display("Test failed");
			$fatal(1, "read data check failed");
		end
	endtask

	task automatic check_count(input string name, input cache_pkg::count_t expected,
			input cache_pkg::count_t actual);
		if (actual !== expected) begin
			$display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
			$display("Test failed");
			$fatal(1, "register check failed");
		end
	endtask

	task automatic load_vectors();
		int fd;
		int n;
		string line;
		logic [7:0] op;
		cache_pkg::addr_t a;
		cache_pkg::word_t d;
		cache_pkg::mask_t m;
		cache_pkg::word_t e;
		fd = $fopen("dcache_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file dcache_vectors.txt");
			$display("Test failed");
			$fatal(1, "no vector file");
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			// blank lines and comment lines carry no vector
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			n = $sscanf(line, "%c %h %h %h %h", op, a, d, m, e);
			if (n != 5) begin
				$display("vector file has a line that does not hold five fields");
				$display("Test failed");
				$fatal(1, "bad vector line");
			end
			op_q.push_back(op);
			addr_q.push_back(a);
			data_q.push_back(d);
			mask_q.push_back(m);
			exp_q.push_back(e);
		end
		$fclose(fd);
	endtask

	// one request on the core port, returns dout from the ready cycle
	task automatic core_access(input logic write, input cache_pkg::addr_t a,
			input cache_pkg::word_t d, input cache_pkg::mask_t m,
			output cache_pkg::word_t rd);
		@(posedge clk);
		valid <= 1'b1;
		wren <= write;
		addr <= a;
		din <= d;
		mask <= m;
		// ready and dout settle after the edge, sample mid-cycle
		@(negedge clk);
		while (!ready) begin
			@(negedge clk);
		end
		rd = dout;
		// ready is a single pulse so valid drops right after it
		@(posedge clk);
		valid <= 1'b0;
	endtask

	task automatic cfg_write(input mem_pkg::cfg_addr_t a, input cache_pkg::addr_t d);
		@(posedge clk);
		cfg_we <= 1'b1;
		cfg_addr <= a;
		cfg_wdata <= d;
		@(posedge clk);
		cfg_we <= 1'b0;
	endtask

	// cfg_rdata is combinational from cfg_addr
	task automatic cfg_read(input mem_pkg::cfg_addr_t a, output cache_pkg::count_t rd);
		@(posedge clk);
		cfg_addr <= a;
		@(negedge clk);
		rd = cfg_rdata;
	endtask

	initial begin
		int i;
		string name;
		cache_pkg::word_t rd_word;
		cache_pkg::count_t rd_count;
		rst = 1'b1;
		valid = 1'b0;
		wren = 1'b0;
		addr = '0;
		din = '0;
		mask = '0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		loaded = 1'b0;
		load_vectors();
		vec_count = op_q.size();
		loaded = 1'b1;
		// reset held over three rising edges
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		for (i = 0; i < vec_count; i++) begin
			name = $sformatf("vector %0d (%c)", i + 1, op_q[i]);
			case (op_q[i])
				"R": begin
					core_access(1'b0, addr_q[i], data_q[i], mask_q[i], rd_word);
					check_word(name, exp_q[i], rd_word);
				end
				"W": core_access(1'b1, addr_q[i], data_q[i], mask_q[i], rd_word);
				"C": cfg_write(addr_q[i][1:0], data_q[i][31:0]);
				"Q": begin
					cfg_read(addr_q[i][1:0], rd_count);
					check_count(name, exp_q[i][31:0], rd_count);
				end
				default: begin
					$display("%s has an operation letter that is not R W C or Q", name);
					$display("Test failed");
					$fatal(1, "unknown operation");
				end
			endcase
		end
		@(posedge clk);
		$display("Test passed");
		$finish;
	end

	// worst case is a miss with a full burst, well under the per-vector margin
	initial begin
		int unsigned limit_ns;
		wait (loaded);
		limit_ns = vec_count * (`MEM_LATENCY + 20) * 20;
		#(limit_ns);
		$display("the cache stopped answering requests within %0d ns", limit_ns);
		$display("Test failed");
		$fatal(1, "watchdog timeout");
	end

endmodule

// ==== dcache_vectors.txt ====
# op letter then addr data mask and expected value in hex
# R read  W write  C config write  Q config read with the register number as addr
W 00000048 1122334455667788 ff 0000000000000000
R 00000048 0000000000000000 00 1122334455667788
R 00000048 0000000000000000 00 1122334455667788
W 00000088 aaaaaaaaaaaaaaaa ff 0000000000000000
W 00000088 00000000bbbbbbbb 0f 0000000000000000
R 00000088 0000000000000000 00 aaaaaaaabbbbbbbb
R 00000088 0000000000000000 00 aaaaaaaabbbbbbbb
R 00000080 0000000000000000 00 0000000000000000
W 00000088 123456789abcdef0 3c 0000000000000000
R 00000088 0000000000000000 00 aaaa56789abcbbbb
Q 00000002 0000000000000000 00 0000000000000004
C 00000002 0000000000000000 00 0000000000000000
Q 00000002 0000000000000000 00 0000000000000000
W 000000c0 00000000000000a0 ff 0000000000000000
W 000004c0 00000000000000a1 ff 0000000000000000
W 000008c0 00000000000000a2 ff 0000000000000000
W 00000cc0 00000000000000a3 ff 0000000000000000
W 000010c0 00000000000000a4 ff 0000000000000000
R 000000c0 0000000000000000 00 00000000000000a0
R 000004c0 0000000000000000 00 00000000000000a1
R 000008c0 0000000000000000 00 00000000000000a2
R 00000cc0 0000000000000000 00 00000000000000a3
R 000010c0 0000000000000000 00 00000000000000a4
R 000010c0 0000000000000000 00 00000000000000a4
Q 00000002 0000000000000000 00 0000000000000001
R 000000c0 0000000000000000 00 00000000000000a0
Q 00000003 0000000000000000 00 0000000000000008
C 00000001 0000000000001000 00 0000000000000000
W 00001800 cafef00ddeadbeef ff 0000000000000000
R 00001800 0000000000000000 00 cafef00ddeadbeef
R 000010c0 0000000000000000 00 00000000000000a4
Q 00000002 0000000000000000 00 0000000000000001
Q 00000003 0000000000000000 00 0000000000000008
C 00000001 0000000000002000 00 0000000000000000
R 00000048 0000000000000000 00 1122334455667788
C 00000000 0000000000000003 00 0000000000000000
R 00000048 0000000000000000 00 1122334455667788
Q 00000003 0000000000000000 00 0000000000000009
Q 00000002 0000000000000000 00 0000000000000002
C 00000000 0000000000000000 00 0000000000000000
R 00000088 0000000000000000 00 aaaa56789abcbbbb
Q 00000002 0000000000000000 00 0000000000000002
Q 00000003 0000000000000000 00 0000000000000009
C 00000000 0000000000000001 00 0000000000000000
R 00000048 0000000000000000 00 1122334455667788
Q 00000002 0000000000000000 00 0000000000000003
C 00000003 0000000000000000 00 0000000000000000
Q 00000003 0000000000000000 00 0000000000000000

// ==== dcache_subsys.f ====
+incdir+.
cache_pkg.sv
mem_pkg.sv
dcache_cfg_regs.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_ctrl.sv
burst_mem.sv
dcache_subsys.sv
tb_dcache_subsys.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP ?= tb_dcache_subsys
FILELIST ?= dcache_subsys.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST) dcache_macros.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) dcache_vectors.txt
	-./$(SIM) | tee $(LOG)
	@grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
